// File: fight_geom_pkg.sv
package fight_geom_pkg;

  // Screen x coordinate.
  typedef logic [9:0] pos_t;

  // Horizontal clamp limits for posx.
  localparam pos_t ARENA_MIN_X = 10'd50;
  localparam pos_t ARENA_MAX_X = 10'd490;

  // Positions after reset.
  localparam pos_t START_X_LEFT  = 10'd210;
  localparam pos_t START_X_RIGHT = 10'd420;

  // Both fighters stand on this line.
  localparam int FLOOR_Y = 170;

  // Attack box edges relative to posx.
  localparam pos_t ATK_OFS_X1 = 10'd37;
  localparam pos_t ATK_OFS_X2 = 10'd113;

  // Body box edges relative to posx.
  localparam pos_t BODY_OFS_X1 = 10'd37;
  localparam pos_t BODY_OFS_X2 = 10'd86;

  // Vertical box extents relative to FLOOR_Y.
  localparam int ATK_OFS_Y1 = 24;
  localparam int ATK_OFS_Y2 = 57;
  localparam int BODY_H     = 150;

endpackage

// File: fight_ctrl_pkg.sv
package fight_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    MOVE_FWD    = 3'd1,
    MOVE_BACK   = 3'd2,
    ATK_WINDUP  = 3'd3,
    ATK_ACTIVE  = 3'd4,
    ATK_RECOVER = 3'd5
  } fighter_state_t;

  // Attack phase lengths in cycles.
  localparam int WINDUP_CYCLES  = 5;
  localparam int ACTIVE_CYCLES  = 2;
  localparam int RECOVER_CYCLES = 16;

  // Counter holds 0 to RECOVER_CYCLES-1.
  localparam int PHASE_W = $clog2(RECOVER_CYCLES);

  // Pixels per move cycle.
  localparam int MOVE_SPEED = 15;

  typedef logic [6:0] health_t;

  localparam health_t MAX_HEALTH = 7'd100;
  localparam health_t HIT_DAMAGE = 7'd10;

endpackage

// File: button_sync.sv
`timescale 1ns/1ns

module button_sync (
  input  logic clk,
  input  logic rst,
  input  logic left,
  input  logic right,
  input  logic attack,
  output logic left_s,
  output logic right_s,
  output logic attack_rise
);

  logic left_q1;
  logic left_q2;
  logic right_q1;
  logic right_q2;
  logic atk_q1;
  logic atk_q2;
  logic atk_q3;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      left_q1  <= 1'b0;
      left_q2  <= 1'b0;
      right_q1 <= 1'b0;
      right_q2 <= 1'b0;
      atk_q1   <= 1'b0;
      atk_q2   <= 1'b0;
      atk_q3   <= 1'b0;
    end else begin
      left_q1  <= left;
      left_q2  <= left_q1;
      right_q1 <= right;
      right_q2 <= right_q1;
      atk_q1   <= attack;
      atk_q2   <= atk_q1;
      atk_q3   <= atk_q2; // Previous synced level.
    end
  end

  assign left_s      = left_q2;
  assign right_s     = right_q2;
  assign attack_rise = atk_q2 & ~atk_q3; // One pulse per press.

endmodule

// File: fighter.sv
`timescale 1ns/1ns

module fighter
  import fight_geom_pkg::*;
  import fight_ctrl_pkg::*;
#(
  parameter bit SIDE = 1'b0
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           left,
  input  logic           right,
  input  logic           attack_rise,
  input  logic           freeze,
  output pos_t           posx,
  output fighter_state_t state,
  output pos_t           atk_x1,
  output pos_t           atk_x2,
  output pos_t           body_x1,
  output pos_t           body_x2,
  output logic           atk_live
);

  fighter_state_t     state_nxt;
  logic [PHASE_W-1:0] phase_cnt;
  logic [PHASE_W-1:0] cnt_nxt;
  logic               fwd_req;
  logic               back_req;
  logic               go_right;
  logic               moving;
  pos_t               posx_nxt;
  int                 x_calc;

  // Facing decides which button is forward.
  always_comb begin
    if (SIDE) begin
      fwd_req = left && !right;
    end else begin
      fwd_req = right && !left;
    end
    back_req = (left || right) && !fwd_req; // Both pressed falls here.
  end

  always_comb begin
    state_nxt = state;
    cnt_nxt   = phase_cnt + 1'b1;
    if (freeze) begin
      state_nxt = IDLE;
      cnt_nxt   = '0;
    end else begin
      case (state)
        IDLE, MOVE_FWD, MOVE_BACK: begin
          cnt_nxt = '0;
          if (attack_rise) begin
            state_nxt = ATK_WINDUP; // Attack beats movement.
          end else if (fwd_req) begin
            state_nxt = MOVE_FWD;
          end else if (back_req) begin
            state_nxt = MOVE_BACK;
          end else begin
            state_nxt = IDLE;
          end
        end
        ATK_WINDUP: begin
          if (phase_cnt == PHASE_W'(WINDUP_CYCLES - 1)) begin
            state_nxt = ATK_ACTIVE;
            cnt_nxt   = '0;
          end
        end
        ATK_ACTIVE: begin
          if (phase_cnt == PHASE_W'(ACTIVE_CYCLES - 1)) begin
            state_nxt = ATK_RECOVER;
            cnt_nxt   = '0;
          end
        end
        ATK_RECOVER: begin
          if (phase_cnt == PHASE_W'(RECOVER_CYCLES - 1)) begin
            state_nxt = IDLE;
            cnt_nxt   = '0;
          end
        end
        default: begin
          state_nxt = IDLE;
          cnt_nxt   = '0;
        end
      endcase
    end
  end

  // Step follows the registered state.
  assign moving   = (state == MOVE_FWD) || (state == MOVE_BACK);
  assign go_right = (state == MOVE_FWD) != SIDE;

  always_comb begin
    if (go_right) begin
      x_calc = int'(posx) + MOVE_SPEED;
    end else begin
      x_calc = int'(posx) - MOVE_SPEED;
    end
    if (x_calc < int'(ARENA_MIN_X)) begin
      posx_nxt = ARENA_MIN_X;
    end else if (x_calc > int'(ARENA_MAX_X)) begin
      posx_nxt = ARENA_MAX_X;
    end else begin
      posx_nxt = pos_t'(x_calc);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= IDLE;
      phase_cnt <= '0;
      posx      <= SIDE ? START_X_RIGHT : START_X_LEFT;
    end else begin
      state     <= state_nxt;
      phase_cnt <= cnt_nxt;
      if (moving && !freeze) begin
        posx <= posx_nxt;
      end
    end
  end

  assign atk_x1  = posx + ATK_OFS_X1;
  assign atk_x2  = posx + ATK_OFS_X2;
  assign body_x1 = posx + BODY_OFS_X1;
  assign body_x2 = posx + BODY_OFS_X2;

  assign atk_live = (state == ATK_ACTIVE);

endmodule

// File: hit_detect.sv
`timescale 1ns/1ns

module hit_detect
  import fight_geom_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  pos_t l_atk_x1,
  input  pos_t l_atk_x2,
  input  pos_t l_body_x1,
  input  pos_t l_body_x2,
  input  logic l_atk_live,
  input  pos_t r_atk_x1,
  input  pos_t r_atk_x2,
  input  pos_t r_body_x1,
  input  pos_t r_body_x2,
  input  logic r_atk_live,
  output logic hit_on_left,
  output logic hit_on_right
);

  logic l_overlap;
  logic r_overlap;
  logic l_landed;
  logic r_landed;

  // Left attack against right body, and the mirror case.
  assign l_overlap = l_atk_live && (l_atk_x1 <= r_body_x2) && (r_body_x1 <= l_atk_x2);
  assign r_overlap = r_atk_live && (r_atk_x1 <= l_body_x2) && (l_body_x1 <= r_atk_x2);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hit_on_left  <= 1'b0;
      hit_on_right <= 1'b0;
      l_landed     <= 1'b0;
      r_landed     <= 1'b0;
    end else begin
      hit_on_right <= l_overlap && !l_landed;
      hit_on_left  <= r_overlap && !r_landed;
      if (!l_atk_live) begin
        l_landed <= 1'b0; // Rearm for next attack.
      end else if (l_overlap) begin
        l_landed <= 1'b1;
      end
      if (!r_atk_live) begin
        r_landed <= 1'b0;
      end else if (r_overlap) begin
        r_landed <= 1'b1;
      end
    end
  end

endmodule

// File: health_tracker.sv
`timescale 1ns/1ns

module health_tracker
  import fight_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    hit_on_left,
  input  logic    hit_on_right,
  output health_t left_health,
  output health_t right_health,
  output logic    round_over
);

  health_t left_nxt;
  health_t right_nxt;

  always_comb begin
    left_nxt  = left_health;
    right_nxt = right_health;
    if (!round_over) begin
      if (hit_on_left) begin
        left_nxt = (left_health > HIT_DAMAGE) ? left_health - HIT_DAMAGE : '0;
      end
      if (hit_on_right) begin
        right_nxt = (right_health > HIT_DAMAGE) ? right_health - HIT_DAMAGE : '0;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      left_health  <= MAX_HEALTH;
      right_health <= MAX_HEALTH;
      round_over   <= 1'b0;
    end else begin
      left_health  <= left_nxt;
      right_health <= right_nxt;
      // Sticky until reset.
      round_over   <= round_over || (left_nxt == '0) || (right_nxt == '0);
    end
  end

endmodule

// File: fight_top.sv
`timescale 1ns/1ns

module fight_top
  import fight_geom_pkg::*;
  import fight_ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  input  logic           p1_left,
  input  logic           p1_right,
  input  logic           p1_attack,
  input  logic           p2_left,
  input  logic           p2_right,
  input  logic           p2_attack,
  output pos_t           p1_posx,
  output pos_t           p2_posx,
  output fighter_state_t p1_state,
  output fighter_state_t p2_state,
  output health_t        p1_health,
  output health_t        p2_health,
  output logic           round_over
);

  logic p1_left_s, p1_right_s, p1_atk_rise;
  logic p2_left_s, p2_right_s, p2_atk_rise;
  pos_t p1_atk_x1, p1_atk_x2, p1_body_x1, p1_body_x2;
  pos_t p2_atk_x1, p2_atk_x2, p2_body_x1, p2_body_x2;
  logic p1_atk_live, p2_atk_live;
  logic hit_on_left, hit_on_right;

  button_sync u_sync_p1 (
    .clk(clk), .rst(rst),
    .left(p1_left), .right(p1_right), .attack(p1_attack),
    .left_s(p1_left_s), .right_s(p1_right_s), .attack_rise(p1_atk_rise)
  );

  button_sync u_sync_p2 (
    .clk(clk), .rst(rst),
    .left(p2_left), .right(p2_right), .attack(p2_attack),
    .left_s(p2_left_s), .right_s(p2_right_s), .attack_rise(p2_atk_rise)
  );

  // Player 1 stands on the left.
  fighter #(.SIDE(1'b0)) u_fighter_p1 (
    .clk(clk), .rst(rst),
    .left(p1_left_s), .right(p1_right_s), .attack_rise(p1_atk_rise), .freeze(round_over),
    .posx(p1_posx), .state(p1_state),
    .atk_x1(p1_atk_x1), .atk_x2(p1_atk_x2),
    .body_x1(p1_body_x1), .body_x2(p1_body_x2), .atk_live(p1_atk_live)
  );

  fighter #(.SIDE(1'b1)) u_fighter_p2 (
    .clk(clk), .rst(rst),
    .left(p2_left_s), .right(p2_right_s), .attack_rise(p2_atk_rise), .freeze(round_over),
    .posx(p2_posx), .state(p2_state),
    .atk_x1(p2_atk_x1), .atk_x2(p2_atk_x2),
    .body_x1(p2_body_x1), .body_x2(p2_body_x2), .atk_live(p2_atk_live)
  );

  hit_detect u_hit (
    .clk(clk), .rst(rst),
    .l_atk_x1(p1_atk_x1), .l_atk_x2(p1_atk_x2),
    .l_body_x1(p1_body_x1), .l_body_x2(p1_body_x2), .l_atk_live(p1_atk_live),
    .r_atk_x1(p2_atk_x1), .r_atk_x2(p2_atk_x2),
    .r_body_x1(p2_body_x1), .r_body_x2(p2_body_x2), .r_atk_live(p2_atk_live),
    .hit_on_left(hit_on_left), .hit_on_right(hit_on_right)
  );

  health_tracker u_health (
    .clk(clk), .rst(rst),
    .hit_on_left(hit_on_left), .hit_on_right(hit_on_right),
    .left_health(p1_health), .right_health(p2_health),
    .round_over(round_over)
  );

endmodule

// File: fight_sva.sv
`timescale 1ns/1ns

module fight_sva
  import fight_geom_pkg::*;
  import fight_ctrl_pkg::*;
(
  input logic           clk,
  input logic           rst,
  input logic           freeze,
  input pos_t           posx,
  input fighter_state_t state
);

  int fail_cnt = 0;

  property posx_in_arena;
    @(posedge clk) disable iff (rst) (posx >= ARENA_MIN_X) && (posx <= ARENA_MAX_X);
  endproperty

  // A freeze may cut an attack short.
  property active_two_cycles;
    @(posedge clk) disable iff (rst || freeze)
      $rose(state == ATK_ACTIVE) |->
        (state == ATK_ACTIVE) ##1 (state == ATK_ACTIVE) ##1 (state != ATK_ACTIVE);
  endproperty

  property windup_then_active;
    @(posedge clk) disable iff (rst || freeze)
      (state == ATK_WINDUP) |=> (state == ATK_WINDUP) || (state == ATK_ACTIVE);
  endproperty

  assert property (posx_in_arena) else begin
    $error("posx outside the arena limits");
    fail_cnt++;
  end

  assert property (active_two_cycles) else begin
    $error("ATK_ACTIVE did not last 2 cycles");
    fail_cnt++;
  end

  assert property (windup_then_active) else begin
    $error("ATK_WINDUP not followed by ATK_ACTIVE");
    fail_cnt++;
  end

endmodule

bind fighter fight_sva u_sva (
  .clk(clk), .rst(rst), .freeze(freeze), .posx(posx), .state(state)
);

// File: tb_fight.sv
`timescale 1ns/1ns

module tb_fight
  import fight_geom_pkg::*;
  import fight_ctrl_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int TEST_CYCLES   = 10 + 720 + 90 + 90 + 350 + 2300;
  localparam int MARGIN_CYCLES = 500;

  logic           clk;
  logic           rst;
  logic           p1_left, p1_right, p1_attack;
  logic           p2_left, p2_right, p2_attack;
  pos_t           p1_posx, p2_posx;
  fighter_state_t p1_state, p2_state;
  health_t        p1_health, p2_health;
  logic           round_over;

  // Reference model, index 0 is player 1 on the left.
  logic           m_lq1 [0:1], m_lq2 [0:1], m_rq1 [0:1], m_rq2 [0:1];
  logic           m_aq1 [0:1], m_aq2 [0:1], m_aq3 [0:1];
  fighter_state_t m_st [0:1];
  int             m_cnt [0:1], m_px [0:1], m_hp [0:1];
  logic           m_landed [0:1], m_hit [0:1];
  logic           m_over;

  logic [31:0] rng;
  int          errors, test_errs, tests_run, tests_failed;

  fight_top uut (
    .clk(clk), .rst(rst),
    .p1_left(p1_left), .p1_right(p1_right), .p1_attack(p1_attack),
    .p2_left(p2_left), .p2_right(p2_right), .p2_attack(p2_attack),
    .p1_posx(p1_posx), .p2_posx(p2_posx), .p1_state(p1_state), .p2_state(p2_state),
    .p1_health(p1_health), .p2_health(p2_health), .round_over(round_over)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_all();
    check_val("p1_posx", p1_posx, m_px[0]);
    check_val("p2_posx", p2_posx, m_px[1]);
    check_val("p1_state", p1_state, m_st[0]);
    check_val("p2_state", p2_state, m_st[1]);
    check_val("p1_health", p1_health, m_hp[0]);
    check_val("p2_health", p2_health, m_hp[1]);
    check_val("round_over", round_over, m_over);
  endtask

  task automatic model_reset();
    for (int p = 0; p < 2; p++) begin
      m_lq1[p] = 0;
      m_lq2[p] = 0;
      m_rq1[p] = 0;
      m_rq2[p] = 0;
      m_aq1[p] = 0;
      m_aq2[p] = 0;
      m_aq3[p] = 0;
      m_st[p] = IDLE;
      m_cnt[p] = 0;
      m_hp[p] = MAX_HEALTH;
      m_landed[p] = 0;
      m_hit[p] = 0;
    end
    m_px[0] = START_X_LEFT;
    m_px[1] = START_X_RIGHT;
    m_over = 0;
  endtask

  // One clock edge of the whole chain, every next value from the old ones.
  task automatic model_step();
    logic           in_l [0:1], in_r [0:1], in_a [0:1];
    fighter_state_t n_st [0:1];
    int             n_cnt [0:1], n_px [0:1], n_hp [0:1];
    logic           n_landed [0:1], n_hit [0:1];
    logic           rise, fwd, back, live, ovl;
    int             step, q;
    in_l[0] = p1_left;
    in_r[0] = p1_right;
    in_a[0] = p1_attack;
    in_l[1] = p2_left;
    in_r[1] = p2_right;
    in_a[1] = p2_attack;
    for (int p = 0; p < 2; p++) begin
      q = 1 - p;
      rise = m_aq2[p] && !m_aq3[p];
      fwd = (p == 1) ? (m_lq2[p] && !m_rq2[p]) : (m_rq2[p] && !m_lq2[p]);
      back = (m_lq2[p] || m_rq2[p]) && !fwd;
      n_st[p] = m_st[p];
      n_cnt[p] = 0;
      if (m_over) begin
        n_st[p] = IDLE;
      end else begin
        case (m_st[p])
          ATK_WINDUP: begin
            if (m_cnt[p] == WINDUP_CYCLES - 1) n_st[p] = ATK_ACTIVE;
            else n_cnt[p] = m_cnt[p] + 1;
          end
          ATK_ACTIVE: begin
            if (m_cnt[p] == ACTIVE_CYCLES - 1) n_st[p] = ATK_RECOVER;
            else n_cnt[p] = m_cnt[p] + 1;
          end
          ATK_RECOVER: begin
            if (m_cnt[p] == RECOVER_CYCLES - 1) n_st[p] = IDLE;
            else n_cnt[p] = m_cnt[p] + 1;
          end
          default: begin
            if (rise) n_st[p] = ATK_WINDUP;
            else if (fwd) n_st[p] = MOVE_FWD;
            else if (back) n_st[p] = MOVE_BACK;
            else n_st[p] = IDLE;
          end
        endcase
      end
      n_px[p] = m_px[p];
      if (!m_over && (m_st[p] == MOVE_FWD || m_st[p] == MOVE_BACK)) begin
        step = (m_st[p] == MOVE_FWD) ? MOVE_SPEED : -MOVE_SPEED;
        if (p == 1) step = -step; // Right fighter faces left.
        n_px[p] = m_px[p] + step;
        if (n_px[p] < int'(ARENA_MIN_X)) n_px[p] = ARENA_MIN_X;
        if (n_px[p] > int'(ARENA_MAX_X)) n_px[p] = ARENA_MAX_X;
      end
      live = (m_st[p] == ATK_ACTIVE);
      ovl = live && (m_px[p] + int'(ATK_OFS_X1) <= m_px[q] + int'(BODY_OFS_X2))
                 && (m_px[q] + int'(BODY_OFS_X1) <= m_px[p] + int'(ATK_OFS_X2));
      n_hit[p] = ovl && !m_landed[p];
      n_landed[p] = live && (m_landed[p] || ovl);
      n_hp[p] = m_hp[p];
      if (!m_over && m_hit[q]) begin
        n_hp[p] = (m_hp[p] > int'(HIT_DAMAGE)) ? m_hp[p] - int'(HIT_DAMAGE) : 0;
      end
    end
    m_over = m_over || (n_hp[0] == 0) || (n_hp[1] == 0);
    for (int p = 0; p < 2; p++) begin
      m_aq3[p] = m_aq2[p];
      m_aq2[p] = m_aq1[p];
      m_aq1[p] = in_a[p];
      m_lq2[p] = m_lq1[p];
      m_lq1[p] = in_l[p];
      m_rq2[p] = m_rq1[p];
      m_rq1[p] = in_r[p];
      m_st[p] = n_st[p];
      m_cnt[p] = n_cnt[p];
      m_px[p] = n_px[p];
      m_hp[p] = n_hp[p];
      m_landed[p] = n_landed[p];
      m_hit[p] = n_hit[p];
    end
  endtask

  // Button vectors are {attack, right, left}.
  task automatic set_buttons(input logic [2:0] b1, input logic [2:0] b2);
    p1_left = b1[0];
    p1_right = b1[1];
    p1_attack = b1[2];
    p2_left = b2[0];
    p2_right = b2[1];
    p2_attack = b2[2];
  endtask

  task automatic advance();
    @(posedge clk);
    model_step();
    #5;
    check_all();
  endtask

  task automatic hold(input logic [2:0] b1, input logic [2:0] b2, input int n);
    set_buttons(b1, b2);
    repeat (n) advance();
  endtask

  task automatic apply_reset();
    set_buttons(3'b000, 3'b000);
    rst = 1'b1;
    model_reset();
    repeat (3) @(posedge clk);
    #5;
    rst = 1'b0;
    check_all();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("Test %s ok", name);
    end else begin
      tests_failed++;
      $display("Test %s FAILED with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] r;
    int          n_wind, n_act, n_rec, len, cycles;
    int          sva_fails;
    pos_t        save1, save2;
    clk = 1'b0;
    rng = 32'd64537;
    errors = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    apply_reset();
    check_val("p1_posx", p1_posx, 210);
    check_val("p2_posx", p2_posx, 420);
    hold(3'b000, 3'b000, 4);
    finish_test("reset");

    repeat (40) begin
      r = next_rand();
      hold({1'b0, r[1:0]}, {1'b0, r[3:2]}, 1 + r[7:4]);
    end
    hold(3'b001, 3'b010, 30); // Push both to the walls.
    hold(3'b000, 3'b000, 4);
    check_val("p1_posx", p1_posx, 50);
    check_val("p2_posx", p2_posx, 490);
    finish_test("movement");

    apply_reset();
    n_wind = 0;
    n_act = 0;
    n_rec = 0;
    set_buttons(3'b100, 3'b000);
    repeat (40) begin
      advance();
      if (p1_state == ATK_WINDUP) n_wind++;
      if (p1_state == ATK_ACTIVE) n_act++;
      if (p1_state == ATK_RECOVER) n_rec++;
    end
    check_val("p1_state windup count", n_wind, 5);
    check_val("p1_state active count", n_act, 2);
    check_val("p1_state recover count", n_rec, 16);
    hold(3'b000, 3'b111, 30); // Moves held through the attack.
    hold(3'b000, 3'b000, 4);
    finish_test("attack");

    apply_reset();
    hold(3'b010, 3'b000, 10); // Close to 60 pixels apart.
    hold(3'b000, 3'b000, 4);
    hold(3'b100, 3'b000, 1);
    hold(3'b000, 3'b000, 30);
    check_val("p2_health", p2_health, 90);
    hold(3'b000, 3'b100, 1); // Out of range.
    hold(3'b000, 3'b000, 30);
    check_val("p1_health", p1_health, 100);
    check_val("p2_health", p2_health, 90);
    finish_test("hits");

    repeat (9) begin
      hold(3'b100, 3'b000, 1);
      hold(3'b000, 3'b000, 30);
    end
    check_val("p2_health", p2_health, 0);
    check_val("round_over", round_over, 1);
    check_val("p1_state", p1_state, IDLE);
    check_val("p2_state", p2_state, IDLE);
    save1 = pos_t'(m_px[0]);
    save2 = pos_t'(m_px[1]);
    repeat (6) begin
      r = next_rand();
      hold(r[2:0], r[5:3], 10);
    end
    check_val("p1_posx", p1_posx, save1);
    check_val("p2_posx", p2_posx, save2);
    check_val("p1_health", p1_health, 100);
    check_val("p2_health", p2_health, 0);
    finish_test("round end");

    apply_reset();
    cycles = 0;
    while (cycles < 2000) begin
      r = next_rand();
      len = 1 + r[7:4];
      hold({r[9:8] == 2'b00, r[11:10]}, {r[13:12] == 2'b00, r[15:14]}, len);
      cycles += len;
      if (m_over) apply_reset(); // Start a fresh round.
    end
    finish_test("mixed play");

    sva_fails = uut.u_fighter_p1.u_sva.fail_cnt + uut.u_fighter_p2.u_sva.fail_cnt;
    $display("Tests run %0d, tests failed %0d, failed checks %0d, assertion failures %0d",
             tests_run, tests_failed, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
fight_geom_pkg.sv
fight_ctrl_pkg.sv
button_sync.sv
fighter.sv
hit_detect.sv
health_tracker.sv
fight_top.sv
fight_sva.sv
tb_fight.sv
